// ==== verilog/rvCore_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data path and PC width
`define XLEN 32

`define NUM_REGS 32

// Anything else in instr[1:0] is a compressed or reserved encoding
`define INSTR_LOW_BITS 2'b11

`define PC_STEP 32'd4

`endif

// ==== verilog/rvCorePkg.sv ====
package rvCorePkg;

    // Major opcode from instr[6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100   // ECALL and EBREAK trap
    } OpCode;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        COMP  = 4'd2,   // Set on less than
        XOR   = 4'd3,
        XNOR  = 4'd4,   // All ones when operands match
        OR    = 4'd5,
        AND   = 4'd6,
        LSHFT = 4'd7,
        RSHFT = 4'd8
    } AluCtrl;

    // funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        FN_ADD_OR_SUB = 3'b000,
        FN_SLL        = 3'b001,
        FN_SLT        = 3'b010,
        FN_SLTU       = 3'b011,
        FN_XOR        = 3'b100,
        FN_SRLA       = 3'b101,   // SRL or SRA by funct7[5]
        FN_OR         = 3'b110,
        FN_AND        = 3'b111
    } AluFunct;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } BranchCmd;

    typedef enum logic [1:0] {
        BITS8  = 2'b00,
        BITS16 = 2'b01,
        BITS32 = 2'b10,
        ERRVAL = 2'b11
    } LsWidth;

    typedef logic [4:0] RegAddr;

endpackage

// ==== verilog/instrStencil.sv ====
`timescale 1ns/1ns

`include "rvCore_params.svh"

module instrStencil
    import rvCorePkg::*;
(
    input  logic [31:0]       instr,
    output OpCode             opCode,
    output RegAddr            rs1,
    output RegAddr            rs2,
    output RegAddr            rd,
    output AluCtrl            aluCtrl,
    output logic              unsignedOrLeft,
    output logic              arithShift,
    output BranchCmd          branchCmd,
    output logic [`XLEN-1:0]  immI,
    output logic [`XLEN-1:0]  immS,
    output logic [`XLEN-1:0]  immB,
    output logic [`XLEN-1:0]  immU,
    output logic [`XLEN-1:0]  immJ,
    output LsWidth            lsWidth,
    output logic              loadSigned,
    output logic              illegal
);

    logic [2:0] funct3;
    logic       altFunct;   // funct7[5] selects SUB and SRA
    logic       isAluOp;
    logic       knownOp;
    AluFunct    aluFunct;

    assign opCode   = OpCode'(instr[6:2]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign altFunct = instr[30];

    assign aluFunct  = AluFunct'(funct3);
    assign branchCmd = BranchCmd'(funct3);
    assign isAluOp   = (opCode == OP) || (opCode == OP_IMM);

    // Sign always comes from instr[31]
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign lsWidth    = LsWidth'(funct3[1:0]);
    assign loadSigned = ~funct3[2];   // LBU/LHU have funct3[2] set

    always_comb begin
        aluCtrl = ADD;   // Address, AUIPC and link sums
        if (opCode == BRANCH) begin
            aluCtrl = branchCmd[2] ? COMP : XNOR;
        end else if (isAluOp) begin
            case (aluFunct)
                FN_ADD_OR_SUB: aluCtrl = (opCode == OP && altFunct) ? SUB : ADD;
                FN_SLL:        aluCtrl = LSHFT;
                FN_SLT:        aluCtrl = COMP;
                FN_SLTU:       aluCtrl = COMP;
                FN_XOR:        aluCtrl = XOR;
                FN_SRLA:       aluCtrl = RSHFT;
                FN_OR:         aluCtrl = OR;
                FN_AND:        aluCtrl = AND;
                default:       aluCtrl = ADD;
            endcase
        end
    end

    // Branches keep the unsigned flag in funct3[1], ALU ops in funct3[0]
    assign unsignedOrLeft = (opCode == BRANCH) ? funct3[1] : funct3[0];
    assign arithShift     = isAluOp && (aluFunct == FN_SRLA) && altFunct;

    always_comb begin
        case (opCode)
            LOAD,
            OP_IMM,
            OP,
            LUI,
            AUIPC,
            BRANCH,
            JAL,
            JALR:    knownOp = 1'b1;
            STORE:   knownOp = ~funct3[2];   // No store wider than a word
            default: knownOp = 1'b0;         // SYSTEM and unassigned
        endcase
    end

    assign illegal = !knownOp || (instr[1:0] != `INSTR_LOW_BITS);

endmodule

// ==== verilog/rvAlu.sv ====
`timescale 1ns/1ns

`include "rvCore_params.svh"

module rvAlu
    import rvCorePkg::*;
(
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  AluCtrl           aluCtrl,
    input  logic             unsignedOrLeft,
    input  logic             arithShift,
    output logic [`XLEN-1:0] aluResult
);

    localparam int shiftBits = $clog2(`XLEN);

    logic [shiftBits-1:0] shAmt;
    logic                 lessThan;
    logic                 isEqual;
    logic [`XLEN-1:0]     rightShifted;

    assign shAmt = opB[shiftBits-1:0];   // Upper bits of opB ignored

    always_comb begin
        if (unsignedOrLeft) begin
            lessThan = opA < opB;
        end else begin
            lessThan = $signed(opA) < $signed(opB);
        end
    end

    // Reduce the bitwise XNOR so a mismatch gives zero
    assign isEqual = &(~(opA ^ opB));

    always_comb begin
        if (arithShift) begin
            rightShifted = $signed(opA) >>> shAmt;
        end else begin
            rightShifted = opA >> shAmt;
        end
    end

    always_comb begin
        case (aluCtrl)
            ADD: begin
                aluResult = opA + opB;
            end
            SUB: begin
                aluResult = opA - opB;
            end
            COMP: begin
                aluResult = {{(`XLEN-1){1'b0}}, lessThan};
            end
            XOR: begin
                aluResult = opA ^ opB;
            end
            XNOR: begin
                aluResult = {`XLEN{isEqual}};
            end
            OR: begin
                aluResult = opA | opB;
            end
            AND: begin
                aluResult = opA & opB;
            end
            LSHFT: begin
                aluResult = opA << shAmt;
            end
            RSHFT: begin
                aluResult = rightShifted;
            end
            default: begin
                aluResult = '0;   // Unused encodings
            end
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ns

`include "rvCore_params.svh"

module regFile
    import rvCorePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  RegAddr           rs1,
    input  RegAddr           rs2,
    input  logic             wrEn,
    input  RegAddr           wrAddr,
    input  logic [`XLEN-1:0] wrData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;   // x0 never written
        end
    end

    // Old value during the writing cycle, new one from the next
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    wrAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(wrAddr)
    ) else $error("regFile write with unknown address");

endmodule

// ==== verilog/commitSelect.sv ====
`timescale 1ns/1ns

`include "rvCore_params.svh"

module commitSelect
    import rvCorePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  logic [`XLEN-1:0] pc,
    input  OpCode            opCode,
    input  RegAddr           rd,
    input  BranchCmd         branchCmd,
    input  logic             unsignedOrLeft,
    input  logic [`XLEN-1:0] immI,
    input  logic [`XLEN-1:0] immS,
    input  logic [`XLEN-1:0] immB,
    input  logic [`XLEN-1:0] immU,
    input  logic [`XLEN-1:0] immJ,
    input  LsWidth           lsWidth,
    input  logic             loadSigned,
    input  logic             illegal,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] opA,
    output logic [`XLEN-1:0] opB,
    output logic             wrEn,
    output RegAddr           wrAddr,
    output logic [`XLEN-1:0] wrData,
    output logic             retireValid,
    output logic [`XLEN-1:0] retirePc,
    output logic [`XLEN-1:0] nextPc,
    output logic             rdWrite,
    output RegAddr           rdAddr,
    output logic [`XLEN-1:0] rdData,
    output logic             memRead,
    output logic             memWrite,
    output logic [`XLEN-1:0] memAddr,
    output LsWidth           memWidth,
    output logic             memSigned,
    output logic [`XLEN-1:0] memData,
    output logic             trap
);

    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] jalrSum;
    logic [`XLEN-1:0] nextPcD;
    logic             taken;
    logic             writesRd;
    logic             doLoad;
    logic             doStore;

    assign pcPlus4 = pc + `PC_STEP;
    assign jalrSum = rs1Data + immI;

    always_comb begin
        opA = rs1Data;
        opB = rs2Data;   // OP and BRANCH
        case (opCode)
            OP_IMM,
            LOAD: begin
                opB = immI;
            end
            STORE: begin
                opB = immS;
            end
            AUIPC: begin
                opA = pc;
                opB = immU;
            end
            JAL: begin
                opA = pc;
                opB = immJ;   // ALU forms the jump target
            end
            JALR: begin
                opA = pc;
                opB = immI;
            end
            default: begin
            end
        endcase
    end

    // BNE, BGE and BGEU invert the compare
    assign taken = (aluResult != '0) ^ branchCmd[0];

    always_comb begin
        case (opCode)
            BRANCH:  nextPcD = taken ? (pc + immB) : pcPlus4;
            JAL:     nextPcD = aluResult;
            JALR:    nextPcD = {jalrSum[`XLEN-1:1], 1'b0};
            default: nextPcD = pcPlus4;
        endcase
    end

    always_comb begin
        writesRd = 1'b0;
        wrData   = aluResult;
        case (opCode)
            OP,
            OP_IMM,
            AUIPC: begin
                writesRd = 1'b1;
            end
            LUI: begin
                writesRd = 1'b1;
                wrData   = immU;
            end
            JAL,
            JALR: begin
                writesRd = 1'b1;
                wrData   = pcPlus4;   // Link address
            end
            default: begin
            end
        endcase
    end

    assign wrEn    = instrValid && writesRd && !illegal;
    assign wrAddr  = rd;
    assign doLoad  = instrValid && !illegal && (opCode == LOAD);
    assign doStore = instrValid && !illegal && (opCode == STORE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retireValid <= 1'b0;
            rdWrite     <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            trap        <= 1'b0;
            retirePc    <= '0;
            nextPc      <= '0;
            rdAddr      <= '0;
            rdData      <= '0;
            memAddr     <= '0;
            memWidth    <= BITS8;
            memSigned   <= 1'b0;
            memData     <= '0;
        end else begin
            retireValid <= instrValid;
            rdWrite     <= wrEn && (rd != '0);   // x0 target reports no write
            memRead     <= doLoad;
            memWrite    <= doStore;
            trap        <= instrValid && illegal;
            if (instrValid) begin
                retirePc  <= pc;
                nextPc    <= nextPcD;
                rdAddr    <= rd;
                rdData    <= wrData;
                memAddr   <= aluResult;   // rs1 plus I or S immediate
                memWidth  <= lsWidth;
                memSigned <= loadSigned;
                memData   <= rs2Data;
            end
        end
    end

    opCodeKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        instrValid |-> !$isunknown(opCode)
    ) else $error("Valid instruction with unknown opcode bits");

    memExclusive: assert property (
        @(posedge clk) disable iff (!arstN)
        !(memRead && memWrite)
    ) else $error("Load and store retired together");

    trapNoWrite: assert property (
        @(posedge clk) disable iff (!arstN)
        trap |-> (!rdWrite && !memRead && !memWrite)
    ) else $error("Trapped instruction had a side effect");

endmodule

// ==== verilog/rvExecUnit.sv ====
`timescale 1ns/1ns

`include "rvCore_params.svh"

module rvExecUnit
    import rvCorePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] pc,
    output logic             retireValid,
    output logic [`XLEN-1:0] retirePc,
    output logic [`XLEN-1:0] nextPc,
    output logic             rdWrite,
    output RegAddr           rdAddr,
    output logic [`XLEN-1:0] rdData,
    output logic             memRead,
    output logic             memWrite,
    output logic [`XLEN-1:0] memAddr,
    output LsWidth           memWidth,
    output logic             memSigned,
    output logic [`XLEN-1:0] memData,
    output logic             trap
);

    OpCode            opCode;
    RegAddr           rs1;
    RegAddr           rs2;
    RegAddr           rd;
    AluCtrl           aluCtrl;
    logic             unsignedOrLeft;
    logic             arithShift;
    BranchCmd         branchCmd;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    LsWidth           lsWidth;
    logic             loadSigned;
    logic             illegal;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic             wrEn;
    RegAddr           wrAddr;
    logic [`XLEN-1:0] wrData;

    instrStencil decoder (
        .instr, .opCode, .rs1, .rs2, .rd, .aluCtrl, .unsignedOrLeft, .arithShift,
        .branchCmd, .immI, .immS, .immB, .immU, .immJ, .lsWidth, .loadSigned, .illegal
    );

    regFile regs (
        .clk, .arstN, .rs1, .rs2, .wrEn, .wrAddr, .wrData, .rs1Data, .rs2Data
    );

    rvAlu alu (
        .opA, .opB, .aluCtrl, .unsignedOrLeft, .arithShift, .aluResult
    );

    commitSelect commit (
        .clk, .arstN, .instrValid, .pc, .opCode, .rd, .branchCmd, .unsignedOrLeft,
        .immI, .immS, .immB, .immU, .immJ, .lsWidth, .loadSigned, .illegal,
        .rs1Data, .rs2Data, .aluResult, .opA, .opB, .wrEn, .wrAddr, .wrData,
        .retireValid, .retirePc, .nextPc, .rdWrite, .rdAddr, .rdData,
        .memRead, .memWrite, .memAddr, .memWidth, .memSigned, .memData, .trap
    );

endmodule

// ==== tb/rvExecUnitTb.sv ====
`timescale 1ns/1ns

module rvExecUnitTb;

    localparam int randomOps = 40;
    localparam logic [6:0] opLoad   = 7'h03;
    localparam logic [6:0] opImm    = 7'h13;
    localparam logic [6:0] opAuipc  = 7'h17;
    localparam logic [6:0] opStore  = 7'h23;
    localparam logic [6:0] opReg    = 7'h33;
    localparam logic [6:0] opLui    = 7'h37;
    localparam logic [6:0] opBranch = 7'h63;
    localparam logic [6:0] opJalr   = 7'h67;
    localparam logic [6:0] opJal    = 7'h6f;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic        rdWrite;
        logic [4:0]  rdAddr;
        logic [31:0] rdData;
        logic        memRead;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [1:0]  memWidth;
        logic        memSigned;
        logic [31:0] memData;
        logic        trap;
    } RetireVec;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [31:0] nextPc;
    logic        rdWrite;
    logic [4:0]  rdAddr;
    logic [31:0] rdData;
    logic        memRead;
    logic        memWrite;
    logic [31:0] memAddr;
    logic [1:0]  memWidth;
    logic        memSigned;
    logic [31:0] memData;
    logic        trap;

    RetireVec    vectors[$];
    logic [31:0] curPc;
    integer      seed;
    int          errorCount;
    int          checkCount;
    logic        tableReady;

    rvExecUnit uut (
        .clk, .arstN, .instrValid, .instr, .pc, .retireValid, .retirePc, .nextPc,
        .rdWrite, .rdAddr, .rdData, .memRead, .memWrite, .memAddr, .memWidth,
        .memSigned, .memData, .trap
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // RV32I register-register semantics
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];   // Sign bit fills from the left
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic RetireVec startVec(input logic [31:0] ins);
        RetireVec v;
        v = '0;
        v.valid  = 1'b1;
        v.instr  = ins;
        v.pc     = curPc;
        v.nextPc = curPc + 32'd4;
        return v;
    endfunction

    task automatic appendVec(input RetireVec v);
        vectors.push_back(v);
        if (v.valid) begin
            curPc = curPc + 32'd4;
        end
    endtask

    // rd of zero means no write is expected
    task automatic flowCase(input logic [31:0] ins, input logic [4:0] rd,
                            input logic [31:0] value, input logic [31:0] target);
        RetireVec v;
        v = startVec(ins);
        v.nextPc  = target;
        v.rdWrite = (rd != 5'd0);
        v.rdAddr  = rd;
        v.rdData  = value;
        appendVec(v);
    endtask

    task automatic writeCase(input logic [31:0] ins, input logic [4:0] rd,
                             input logic [31:0] value);
        flowCase(ins, rd, value, curPc + 32'd4);
    endtask

    task automatic memCase(input logic [31:0] ins, input logic store, input logic [31:0] addr,
                           input logic [1:0] width, input logic sgn, input logic [31:0] data);
        RetireVec v;
        v = startVec(ins);
        v.memRead   = !store;
        v.memWrite  = store;
        v.memAddr   = addr;
        v.memWidth  = width;
        v.memSigned = sgn;
        v.memData   = data;
        appendVec(v);
    endtask

    task automatic trapCase(input logic [31:0] ins);
        RetireVec v;
        v = startVec(ins);
        v.trap = 1'b1;
        appendVec(v);
    endtask

    task automatic idleCase();
        RetireVec v;
        v = '0;
        v.instr = 32'h0000_0073;   // Would trap if it were accepted
        appendVec(v);
    endtask

    task automatic buildTable();
        curPc = 32'h0000_00fc;
        writeCase(encR(7'h00, 5'd31, 5'd30, 3'd6, 5'd24), 5'd24, 32'h0);   // Regs clear
        writeCase(encI(12'd5, 5'd0, 3'd0, 5'd1, opImm), 5'd1, 32'h5);
        writeCase(encI(12'hffd, 5'd0, 3'd0, 5'd2, opImm), 5'd2, 32'hffff_fffd);
        writeCase(encI(12'h0f0, 5'd1, 3'd4, 5'd3, opImm), 5'd3, 32'hf5);
        writeCase(encI(12'd1, 5'd2, 3'd2, 5'd4, opImm), 5'd4, 32'h1);
        writeCase(encI(12'd1, 5'd2, 3'd3, 5'd5, opImm), 5'd5, 32'h0);
        writeCase(encI(12'h004, 5'd1, 3'd1, 5'd6, opImm), 5'd6, 32'h50);
        writeCase(encI(12'h401, 5'd2, 3'd5, 5'd7, opImm), 5'd7, 32'hffff_fffe);
        writeCase(encI(12'h01c, 5'd2, 3'd5, 5'd8, opImm), 5'd8, 32'hf);
        writeCase(encI(12'd7, 5'd1, 3'd0, 5'd0, opImm), 5'd0, 32'h0);   // x0 target
        writeCase(encI(12'h011, 5'd0, 3'd0, 5'd9, opImm), 5'd9, 32'h11);
        idleCase();
        writeCase(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), 5'd10, 32'h2);
        writeCase(encR(7'h20, 5'd1, 5'd10, 3'd0, 5'd11), 5'd11, 32'hffff_fffd);
        writeCase(encR(7'h00, 5'd1, 5'd11, 3'd1, 5'd12), 5'd12, 32'hffff_ffa0);
        flowCase(encB(13'd16, 5'd1, 5'd1, 3'd0), 5'd0, 32'h0, 32'h144);
        flowCase(encB(13'd16, 5'd2, 5'd1, 3'd0), 5'd0, 32'h0, 32'h13c);
        flowCase(encB(13'h1ff8, 5'd2, 5'd1, 3'd1), 5'd0, 32'h0, 32'h134);
        flowCase(encB(13'h1ff8, 5'd4, 5'd4, 3'd1), 5'd0, 32'h0, 32'h144);
        flowCase(encB(13'd32, 5'd1, 5'd2, 3'd4), 5'd0, 32'h0, 32'h164);
        flowCase(encB(13'd32, 5'd2, 5'd1, 3'd4), 5'd0, 32'h0, 32'h14c);
        flowCase(encB(13'd16, 5'd2, 5'd1, 3'd5), 5'd0, 32'h0, 32'h15c);
        flowCase(encB(13'd16, 5'd1, 5'd2, 3'd5), 5'd0, 32'h0, 32'h154);
        flowCase(encB(13'd16, 5'd2, 5'd1, 3'd6), 5'd0, 32'h0, 32'h164);
        flowCase(encB(13'd16, 5'd1, 5'd2, 3'd6), 5'd0, 32'h0, 32'h15c);
        flowCase(encB(13'h1ff0, 5'd1, 5'd2, 3'd7), 5'd0, 32'h0, 32'h14c);
        flowCase(encB(13'h1ff0, 5'd2, 5'd1, 3'd7), 5'd0, 32'h0, 32'h164);
        flowCase(encJ(21'h100, 5'd13), 5'd13, 32'h168, 32'h264);
        flowCase(encJ(21'h1fffc0, 5'd14), 5'd14, 32'h16c, 32'h128);
        flowCase(encI(12'h020, 5'd1, 3'd0, 5'd15, opJalr), 5'd15, 32'h170, 32'h24);
        flowCase(encI(12'h104, 5'd2, 3'd0, 5'd16, opJalr), 5'd16, 32'h174, 32'h100);
        writeCase(encU(20'habcde, 5'd17, opLui), 5'd17, 32'habcd_e000);
        writeCase(encU(20'h00012, 5'd18, opAuipc), 5'd18, 32'h0001_2178);
        writeCase(encU(20'hfffff, 5'd19, opAuipc), 5'd19, 32'hffff_f17c);
        memCase(encI(12'd8, 5'd1, 3'd2, 5'd20, opLoad), 1'b0, 32'hd, 2'd2, 1'b1, 32'h0);
        memCase(encI(12'hffc, 5'd2, 3'd4, 5'd21, opLoad), 1'b0, 32'hffff_fff9, 2'd0, 1'b0, 32'h0);
        memCase(encI(12'h010, 5'd3, 3'd1, 5'd22, opLoad), 1'b0, 32'h105, 2'd1, 1'b1, 32'h0);
        memCase(encS(12'd12, 5'd3, 5'd1, 3'd2), 1'b1, 32'h11, 2'd2, 1'b0, 32'hf5);
        memCase(encS(12'hfff, 5'd2, 5'd10, 3'd0), 1'b1, 32'h1, 2'd0, 1'b0, 32'hffff_fffd);
        memCase(encS(12'h7ff, 5'd11, 5'd0, 3'd1), 1'b1, 32'h7ff, 2'd1, 1'b0, 32'hffff_fffd);
        idleCase();
        trapCase(32'h0000_0073);   // ECALL
        trapCase(32'h0000_0fff);   // Unassigned major opcode
        trapCase(encS(12'd0, 5'd1, 5'd1, 3'b100));
        trapCase(encI(12'h077, 5'd0, 3'd0, 5'd1, 7'b0010001));   // Low bits 01
        writeCase(encI(12'd0, 5'd1, 3'd0, 5'd23, opImm), 5'd23, 32'h5);   // x1 untouched
    endtask

    task automatic appendRandomOps();
        logic [31:0] model [9];
        logic [31:0] rnd;
        logic [31:0] value;
        logic [19:0] upper;
        logic [2:0]  f3;
        logic        alt;
        int          s1;
        int          s2;
        int          d;
        model[0] = '0;
        for (int r = 1; r < 9; r++) begin
            value = $random(seed);
            upper = value[31:12] + {19'b0, value[11]};   // ADDI adds the low part sign extended
            writeCase(encU(upper, 5'(r), opLui), 5'(r), {upper, 12'b0});
            writeCase(encI(value[11:0], 5'(r), 3'd0, 5'(r), opImm), 5'(r), value);
            model[r] = value;
        end
        for (int k = 0; k < randomOps; k++) begin
            rnd   = $random(seed);
            f3    = rnd[2:0];
            alt   = rnd[3] && (f3 == 3'd0 || f3 == 3'd5);
            s1    = int'(rnd[7:4]) % 9;
            s2    = int'(rnd[11:8]) % 9;
            d     = int'(rnd[15:12]) % 9;
            value = aluModel(f3, alt, model[s1], model[s2]);
            writeCase(encR(alt ? 7'h20 : 7'h00, 5'(s2), 5'(s1), f3, 5'(d)), 5'(d), value);
            if (d != 0) begin
                model[d] = value;
            end
        end
    endtask

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want, input logic [31:0] atPc);
        checkCount++;
        assert (got === want) else begin
            errorCount++;
            $display("ERROR %s: got 0x%h, expected 0x%h at pc 0x%h", name, got, want, atPc);
        end
    endtask

    task automatic checkReset();
        compareField("retireValid", 32'(retireValid), 32'h0, 32'h0);
        compareField("rdWrite", 32'(rdWrite), 32'h0, 32'h0);
        compareField("memRead", 32'(memRead), 32'h0, 32'h0);
        compareField("memWrite", 32'(memWrite), 32'h0, 32'h0);
        compareField("trap", 32'(trap), 32'h0, 32'h0);
        compareField("retirePc", retirePc, 32'h0, 32'h0);
        compareField("nextPc", nextPc, 32'h0, 32'h0);
        compareField("rdAddr", 32'(rdAddr), 32'h0, 32'h0);
        compareField("rdData", rdData, 32'h0, 32'h0);
        compareField("memAddr", memAddr, 32'h0, 32'h0);
        compareField("memWidth", 32'(memWidth), 32'h0, 32'h0);
        compareField("memSigned", 32'(memSigned), 32'h0, 32'h0);
        compareField("memData", memData, 32'h0, 32'h0);
    endtask

    task automatic checkRetire(input RetireVec v);
        compareField("retireValid", 32'(retireValid), 32'(v.valid), v.pc);
        compareField("rdWrite", 32'(rdWrite), 32'(v.rdWrite), v.pc);
        compareField("memRead", 32'(memRead), 32'(v.memRead), v.pc);
        compareField("memWrite", 32'(memWrite), 32'(v.memWrite), v.pc);
        compareField("trap", 32'(trap), 32'(v.trap), v.pc);
        if (v.valid) begin
            compareField("retirePc", retirePc, v.pc, v.pc);
            if (!v.trap) begin
                compareField("nextPc", nextPc, v.nextPc, v.pc);
            end
            if (v.rdWrite) begin
                compareField("rdAddr", 32'(rdAddr), 32'(v.rdAddr), v.pc);
                compareField("rdData", rdData, v.rdData, v.pc);
            end
            if (v.memRead || v.memWrite) begin
                compareField("memAddr", memAddr, v.memAddr, v.pc);
                compareField("memWidth", 32'(memWidth), 32'(v.memWidth), v.pc);
            end
            if (v.memRead) begin
                compareField("memSigned", 32'(memSigned), 32'(v.memSigned), v.pc);
            end
            if (v.memWrite) begin
                compareField("memData", memData, v.memData, v.pc);
            end
        end
    endtask

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = 32'h0;
        pc         = 32'h0;
        seed       = 32'hceb2_d6bc;
        errorCount = 0;
        checkCount = 0;
        tableReady = 1'b0;
        buildTable();
        appendRandomOps();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkReset();
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            instrValid <= vectors[i].valid;
            instr      <= vectors[i].instr;
            pc         <= vectors[i].pc;
            @(negedge clk);
            if (i > 0) begin
                checkRetire(vectors[i - 1]);   // Retired at the edge just passed
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        checkRetire(vectors[vectors.size() - 1]);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Reset, every vector and some slack
    initial begin
        int cycleLimit;
        wait (tableReady);
        cycleLimit = vectors.size() + 50 + 10;
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== rvExecUnit.f ====
+incdir+verilog
verilog/rvCorePkg.sv
verilog/instrStencil.sv
verilog/rvAlu.sv
verilog/regFile.sv
verilog/commitSelect.sv
verilog/rvExecUnit.sv
tb/rvExecUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the rvExecUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f rvExecUnit.f --top-module rvExecUnitTb --Mdir obj_dir; then
    echo "Verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/VrvExecUnitTb)
simStatus=$?
echo "$simOut"
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
